/* rtl/data_fetch.sv */
`default_nettype none

`include "data_fetch_consts.svh"

module data_fetch (
    input  wire logic                        clk,
    input  wire logic                        resetn,

    // Full frame size in bytes
    input  data_fetch_pkg::frame_bytes_t     frame_size,

    // Command stream
    input  wire logic [7:0]                  cmd_data,
    input  wire logic                        cmd_valid,
    output logic                             cmd_ready,

    // AXI read-address channel toward PCIe
    output data_fetch_pkg::host_addr_t       ar_addr,
    output data_fetch_pkg::burst_len_t       ar_len,
    output logic [2:0]                       ar_size,
    output logic [1:0]                       ar_burst,
    output logic                             ar_valid,
    input  wire logic                        ar_ready,

    // AXI read-data channel
    input  data_fetch_pkg::beat_data_t       r_data,
    input  wire logic                        r_valid,
    output logic                             r_ready,

    // Output stream, no last flag
    output data_fetch_pkg::beat_data_t       out_data,
    output logic                             out_valid,
    input  wire logic                        out_ready,

    // Register port
    input  wire logic                        reg_wr_en,
    input  data_fetch_pkg::reg_index_t       reg_wr_index,
    input  data_fetch_pkg::reg_word_t        reg_wr_data,
    output logic                             reg_wr_err,
    input  wire logic                        reg_rd_en,
    input  data_fetch_pkg::reg_index_t       reg_rd_index,
    output data_fetch_pkg::reg_word_t        reg_rd_data,
    output logic                             reg_rd_valid,
    output logic                             reg_rd_err
);

    // Buffer layout between the register file and the offset keeper
    data_fetch_pkg::host_addr_t fd_base [2][2];
    data_fetch_pkg::host_addr_t md_base [2];
    data_fetch_pkg::host_addr_t fd_bytes;
    data_fetch_pkg::host_addr_t md_bytes;

    ring_ptr_if ptr_link ();

    fetch_regs u_regs (
        .clk          (clk),
        .resetn       (resetn),
        .reg_wr_en    (reg_wr_en),
        .reg_wr_index (reg_wr_index),
        .reg_wr_data  (reg_wr_data),
        .reg_wr_err   (reg_wr_err),
        .reg_rd_en    (reg_rd_en),
        .reg_rd_index (reg_rd_index),
        .reg_rd_data  (reg_rd_data),
        .reg_rd_valid (reg_rd_valid),
        .reg_rd_err   (reg_rd_err),
        .fd_base      (fd_base),
        .md_base      (md_base),
        .fd_bytes     (fd_bytes),
        .md_bytes     (md_bytes)
    );

    ring_pointers u_ptrs (
        .clk        (clk),
        .resetn     (resetn),
        .frame_size (frame_size),
        .fd_base    (fd_base),
        .md_base    (md_base),
        .fd_bytes   (fd_bytes),
        .md_bytes   (md_bytes),
        .link       (ptr_link.keeper)
    );

    read_requester u_req (
        .clk        (clk),
        .resetn     (resetn),
        .frame_size (frame_size),
        .cmd_data   (cmd_data),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .ar_addr    (ar_addr),
        .ar_len     (ar_len),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .link       (ptr_link.sequencer)
    );

    // Full-width beats, incrementing bursts
    assign ar_size  = 3'($clog2(`DF_BEAT_BYTES));
    assign ar_burst = 2'b01;

    // ==========================================================================
    // Read data goes straight out, no buffering
    // ==========================================================================
    assign out_data  = r_data;
    assign out_valid = r_valid;
    assign r_ready   = out_ready;

endmodule

`default_nettype wire

/* rtl/data_fetch_consts.svh */
`ifndef DATA_FETCH_CONSTS_SVH
`define DATA_FETCH_CONSTS_SVH

// PCIe read-data bus width and the bytes in one beat
`define DF_DATA_BITS        512
`define DF_BEAT_BYTES       (`DF_DATA_BITS / 8)

// Frame-data burst and metadata record sizes
`define DF_BURST_BYTES      2048
`define DF_MD_BYTES         128
`define DF_MD_BEATS         2

// Bump whenever the register map changes
`define DF_MODULE_VERSION   1

// ==========================================================================
// Register map
// ==========================================================================
`define DF_REG_MODULE_REV    0
`define DF_REG_HFD00_ADDR_H  1
`define DF_REG_HFD00_ADDR_L  2
`define DF_REG_HFD01_ADDR_H  3
`define DF_REG_HFD01_ADDR_L  4
`define DF_REG_HFD10_ADDR_H  5
`define DF_REG_HFD10_ADDR_L  6
`define DF_REG_HFD11_ADDR_H  7
`define DF_REG_HFD11_ADDR_L  8
`define DF_REG_HMD0_ADDR_H   9
`define DF_REG_HMD0_ADDR_L   10
`define DF_REG_HMD1_ADDR_H   11
`define DF_REG_HMD1_ADDR_L   12
`define DF_REG_HFD_BYTES_H   13
`define DF_REG_HFD_BYTES_L   14
`define DF_REG_HMD_BYTES_H   15
`define DF_REG_HMD_BYTES_L   16

`endif

/* rtl/data_fetch_pkg.sv */
`default_nettype none

`include "data_fetch_consts.svh"

package data_fetch_pkg;

    // Host byte address, also used for buffer sizes and offsets
    typedef logic [63:0] host_addr_t;
    // One beat of PCIe read data
    typedef logic [`DF_DATA_BITS-1:0] beat_data_t;
    // Register port word and index
    typedef logic [31:0] reg_word_t;
    typedef logic [7:0] reg_index_t;
    // AXI burst length field, beats minus one
    typedef logic [7:0] burst_len_t;
    typedef logic [31:0] frame_bytes_t;
    typedef logic phase_t;

    // Command sequencer states
    typedef enum logic [1:0] {
        fs_wait_cmd,
        fs_req_md,
        fs_req_fd_sp0,
        fs_req_fd_sp1
    } fetch_state_t;

    // Which ring offset advances this cycle
    typedef enum logic [1:0] {
        step_none,
        step_md,
        step_fd0,
        step_fd1
    } ptr_step_t;

endpackage

`default_nettype wire

/* rtl/fetch_regs.sv */
`default_nettype none

`include "data_fetch_consts.svh"

module fetch_regs (
    input  wire logic                        clk,
    input  wire logic                        resetn,

    // Write side
    input  wire logic                        reg_wr_en,
    input  data_fetch_pkg::reg_index_t       reg_wr_index,
    input  data_fetch_pkg::reg_word_t        reg_wr_data,
    output logic                             reg_wr_err,

    // Read side, data one cycle after the request
    input  wire logic                        reg_rd_en,
    input  data_fetch_pkg::reg_index_t       reg_rd_index,
    output data_fetch_pkg::reg_word_t        reg_rd_data,
    output logic                             reg_rd_valid,
    output logic                             reg_rd_err,

    // Ring buffer bases, frame data is [phase][semi-phase]
    output data_fetch_pkg::host_addr_t       fd_base [2][2],
    output data_fetch_pkg::host_addr_t       md_base [2],
    output data_fetch_pkg::host_addr_t       fd_bytes,
    output data_fetch_pkg::host_addr_t       md_bytes
);

    // ==========================================================================
    // Write decode
    // ==========================================================================

    // Only 1 to 16 are writable, the version word is read-only
    always_ff @(posedge clk) begin
        if (!resetn) begin
            reg_wr_err <= 1'b0;
        end else begin
            reg_wr_err <= reg_wr_en &&
                          (reg_wr_index < `DF_REG_HFD00_ADDR_H ||
                           reg_wr_index > `DF_REG_HMD_BYTES_L);
        end
    end

    // Each index lands in one 32-bit half
    always_ff @(posedge clk) begin
        if (reg_wr_en) begin
            case (reg_wr_index)
                `DF_REG_HFD00_ADDR_H: fd_base[0][0][63:32] <= reg_wr_data;
                `DF_REG_HFD00_ADDR_L: fd_base[0][0][31:0]  <= reg_wr_data;
                `DF_REG_HFD01_ADDR_H: fd_base[0][1][63:32] <= reg_wr_data;
                `DF_REG_HFD01_ADDR_L: fd_base[0][1][31:0]  <= reg_wr_data;
                `DF_REG_HFD10_ADDR_H: fd_base[1][0][63:32] <= reg_wr_data;
                `DF_REG_HFD10_ADDR_L: fd_base[1][0][31:0]  <= reg_wr_data;
                `DF_REG_HFD11_ADDR_H: fd_base[1][1][63:32] <= reg_wr_data;
                `DF_REG_HFD11_ADDR_L: fd_base[1][1][31:0]  <= reg_wr_data;
                `DF_REG_HMD0_ADDR_H:  md_base[0][63:32]    <= reg_wr_data;
                `DF_REG_HMD0_ADDR_L:  md_base[0][31:0]     <= reg_wr_data;
                `DF_REG_HMD1_ADDR_H:  md_base[1][63:32]    <= reg_wr_data;
                `DF_REG_HMD1_ADDR_L:  md_base[1][31:0]     <= reg_wr_data;
                `DF_REG_HFD_BYTES_H:  fd_bytes[63:32]      <= reg_wr_data;
                `DF_REG_HFD_BYTES_L:  fd_bytes[31:0]       <= reg_wr_data;
                `DF_REG_HMD_BYTES_H:  md_bytes[63:32]      <= reg_wr_data;
                `DF_REG_HMD_BYTES_L:  md_bytes[31:0]       <= reg_wr_data;
                default: ;
            endcase
        end
    end

    // ==========================================================================
    // Read decode
    // ==========================================================================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            reg_rd_valid <= 1'b0;
        end else begin
            reg_rd_valid <= reg_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd_en) begin
            reg_rd_err <= 1'b0;
            case (reg_rd_index)
                `DF_REG_MODULE_REV:   reg_rd_data <= `DF_MODULE_VERSION;
                `DF_REG_HFD00_ADDR_H: reg_rd_data <= fd_base[0][0][63:32];
                `DF_REG_HFD00_ADDR_L: reg_rd_data <= fd_base[0][0][31:0];
                `DF_REG_HFD01_ADDR_H: reg_rd_data <= fd_base[0][1][63:32];
                `DF_REG_HFD01_ADDR_L: reg_rd_data <= fd_base[0][1][31:0];
                `DF_REG_HFD10_ADDR_H: reg_rd_data <= fd_base[1][0][63:32];
                `DF_REG_HFD10_ADDR_L: reg_rd_data <= fd_base[1][0][31:0];
                `DF_REG_HFD11_ADDR_H: reg_rd_data <= fd_base[1][1][63:32];
                `DF_REG_HFD11_ADDR_L: reg_rd_data <= fd_base[1][1][31:0];
                `DF_REG_HMD0_ADDR_H:  reg_rd_data <= md_base[0][63:32];
                `DF_REG_HMD0_ADDR_L:  reg_rd_data <= md_base[0][31:0];
                `DF_REG_HMD1_ADDR_H:  reg_rd_data <= md_base[1][63:32];
                `DF_REG_HMD1_ADDR_L:  reg_rd_data <= md_base[1][31:0];
                `DF_REG_HFD_BYTES_H:  reg_rd_data <= fd_bytes[63:32];
                `DF_REG_HFD_BYTES_L:  reg_rd_data <= fd_bytes[31:0];
                `DF_REG_HMD_BYTES_H:  reg_rd_data <= md_bytes[63:32];
                `DF_REG_HMD_BYTES_L:  reg_rd_data <= md_bytes[31:0];
                // Anything else is a decode error
                default: begin
                    reg_rd_data <= '0;
                    reg_rd_err  <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/read_requester.sv */
`default_nettype none

`include "data_fetch_consts.svh"

module read_requester (
    input  wire logic                        clk,
    input  wire logic                        resetn,
    input  data_fetch_pkg::frame_bytes_t     frame_size,

    // Command stream, bit 0 selects the phase
    input  wire logic [7:0]                  cmd_data,
    input  wire logic                        cmd_valid,
    output logic                             cmd_ready,

    // AXI read-address channel
    output data_fetch_pkg::host_addr_t       ar_addr,
    output data_fetch_pkg::burst_len_t       ar_len,
    output logic                             ar_valid,
    input  wire logic                        ar_ready,

    ring_ptr_if.sequencer                    link
);

    // Beats per frame-data burst, minus one
    localparam data_fetch_pkg::burst_len_t FD_LEN =
        data_fetch_pkg::burst_len_t'(`DF_BURST_BYTES / `DF_BEAT_BYTES - 1);
    localparam data_fetch_pkg::burst_len_t MD_LEN =
        data_fetch_pkg::burst_len_t'(`DF_MD_BEATS - 1);

    data_fetch_pkg::fetch_state_t state;
    data_fetch_pkg::phase_t       phase_q;
    // Bursts issued so far in this semi-phase, counting from 1
    data_fetch_pkg::frame_bytes_t burst_cnt;
    data_fetch_pkg::frame_bytes_t bursts_per_sp;

    logic cmd_fire;
    logic ar_fire;
    logic sp_done;

    assign bursts_per_sp = frame_size / (2 * `DF_BURST_BYTES);

    assign cmd_ready = (state == data_fetch_pkg::fs_wait_cmd);
    assign ar_valid  = (state != data_fetch_pkg::fs_wait_cmd);
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign ar_fire   = ar_valid && ar_ready;
    assign sp_done   = (burst_cnt >= bursts_per_sp);

    // Phase comes straight from the command while idle
    assign link.phase = (state == data_fetch_pkg::fs_wait_cmd) ? cmd_data[0] : phase_q;

    // ==========================================================================
    // Pointer step strobes, one per region start
    // ==========================================================================
    always_comb begin
        link.step = data_fetch_pkg::step_none;
        case (state)
            data_fetch_pkg::fs_wait_cmd:
                if (cmd_fire) link.step = data_fetch_pkg::step_md;
            data_fetch_pkg::fs_req_md:
                if (ar_fire) link.step = data_fetch_pkg::step_fd0;
            data_fetch_pkg::fs_req_fd_sp0:
                if (ar_fire && sp_done) link.step = data_fetch_pkg::step_fd1;
            default: ;
        endcase
    end

    // ==========================================================================
    // Command sequencer
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= data_fetch_pkg::fs_wait_cmd;
        end else begin
            case (state)
                data_fetch_pkg::fs_wait_cmd:
                    if (cmd_fire) state <= data_fetch_pkg::fs_req_md;
                data_fetch_pkg::fs_req_md:
                    if (ar_fire) state <= data_fetch_pkg::fs_req_fd_sp0;
                data_fetch_pkg::fs_req_fd_sp0:
                    if (ar_fire && sp_done) state <= data_fetch_pkg::fs_req_fd_sp1;
                data_fetch_pkg::fs_req_fd_sp1:
                    if (ar_fire && sp_done) state <= data_fetch_pkg::fs_wait_cmd;
                default:
                    state <= data_fetch_pkg::fs_wait_cmd;
            endcase
        end
    end

    // Request payload only moves on an accept, so it holds under stall
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            phase_q <= cmd_data[0];
            ar_addr <= link.md_ptr;
            ar_len  <= MD_LEN;
        end else if (ar_fire) begin
            if (state == data_fetch_pkg::fs_req_md) begin
                // First burst of semi-phase 0
                burst_cnt <= 32'd1;
                ar_addr   <= link.fd0_ptr;
                ar_len    <= FD_LEN;
            end else if (!sp_done) begin
                burst_cnt <= burst_cnt + 32'd1;
                ar_addr   <= ar_addr + `DF_BURST_BYTES;
            end else if (state == data_fetch_pkg::fs_req_fd_sp0) begin
                // Switch over to semi-phase 1
                burst_cnt <= 32'd1;
                ar_addr   <= link.fd1_ptr;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/ring_pointers.sv */
`default_nettype none

`include "data_fetch_consts.svh"

module ring_pointers (
    input  wire logic                        clk,
    input  wire logic                        resetn,
    input  data_fetch_pkg::frame_bytes_t     frame_size,

    // Buffer layout from the register file
    input  data_fetch_pkg::host_addr_t       fd_base [2][2],
    input  data_fetch_pkg::host_addr_t       md_base [2],
    input  data_fetch_pkg::host_addr_t       fd_bytes,
    input  data_fetch_pkg::host_addr_t       md_bytes,

    ring_ptr_if.keeper                       link
);

    // Offsets into each ring, frame data is [phase][semi-phase]
    data_fetch_pkg::host_addr_t md_offs [2];
    data_fetch_pkg::host_addr_t fd_offs [2][2];

    // Frame data advances half a frame per command
    data_fetch_pkg::host_addr_t sp_bytes;
    assign sp_bytes = {33'b0, frame_size[31:1]};

    // Candidate offsets for the selected phase
    data_fetch_pkg::host_addr_t md_next;
    data_fetch_pkg::host_addr_t fd0_next;
    data_fetch_pkg::host_addr_t fd1_next;

    assign md_next  = md_offs[link.phase]    + `DF_MD_BYTES;
    assign fd0_next = fd_offs[link.phase][0] + sp_bytes;
    assign fd1_next = fd_offs[link.phase][1] + sp_bytes;

    // ==========================================================================
    // Offset advance with wrap to the start of the buffer
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            md_offs[0]    <= '0;
            md_offs[1]    <= '0;
            fd_offs[0][0] <= '0;
            fd_offs[0][1] <= '0;
            fd_offs[1][0] <= '0;
            fd_offs[1][1] <= '0;
        end else begin
            case (link.step)
                data_fetch_pkg::step_md:
                    md_offs[link.phase] <= (md_next < md_bytes) ? md_next : '0;
                data_fetch_pkg::step_fd0:
                    fd_offs[link.phase][0] <= (fd0_next < fd_bytes) ? fd0_next : '0;
                data_fetch_pkg::step_fd1:
                    fd_offs[link.phase][1] <= (fd1_next < fd_bytes) ? fd1_next : '0;
                default: ;
            endcase
        end
    end

    // ==========================================================================
    // Host pointers for the phase in use
    // ==========================================================================
    assign link.md_ptr  = md_base[link.phase]    + md_offs[link.phase];
    assign link.fd0_ptr = fd_base[link.phase][0] + fd_offs[link.phase][0];
    assign link.fd1_ptr = fd_base[link.phase][1] + fd_offs[link.phase][1];

endmodule

`default_nettype wire

/* rtl/ring_ptr_if.sv */
`default_nettype none

// Link between the request sequencer and the ring-offset keeper
interface ring_ptr_if;

    // Phase the sequencer is working on
    data_fetch_pkg::phase_t     phase;
    // One-cycle advance strobe
    data_fetch_pkg::ptr_step_t  step;

    // Base plus current offset for the given phase
    data_fetch_pkg::host_addr_t md_ptr;
    data_fetch_pkg::host_addr_t fd0_ptr;
    data_fetch_pkg::host_addr_t fd1_ptr;

    modport sequencer (
        output phase, step,
        input  md_ptr, fd0_ptr, fd1_ptr
    );

    modport keeper (
        input  phase, step,
        output md_ptr, fd0_ptr, fd1_ptr
    );

endinterface

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f sim.f --top-module data_fetch_tb -o data_fetch_sim > sim.log 2>&1 \
    && ./obj_dir/data_fetch_sim >> sim.log 2>&1 \
    || echo "build or simulation exited with an error" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "RESULT: FAIL (no pass line)"; exit 1; }
echo "RESULT: PASS"
exit 0

/* sim.f */
+incdir+rtl
rtl/data_fetch_pkg.sv
rtl/ring_ptr_if.sv
rtl/fetch_regs.sv
rtl/ring_pointers.sv
rtl/read_requester.sv
rtl/data_fetch.sv
sim/data_fetch_assert.sv
sim/data_fetch_tb.sv

/* sim/data_fetch_assert.sv */
`default_nettype none

// Checker bound into data_fetch for the AR channel and the read-data path
module data_fetch_assert (
    input  wire logic                        clk,
    input  wire logic                        resetn,
    input  wire logic                        cmd_valid,
    input  wire logic                        cmd_ready,
    input  data_fetch_pkg::host_addr_t       ar_addr,
    input  data_fetch_pkg::burst_len_t       ar_len,
    input  wire logic                        ar_valid,
    input  wire logic                        ar_ready,
    input  data_fetch_pkg::beat_data_t       r_data,
    input  wire logic                        r_valid,
    input  wire logic                        r_ready,
    input  data_fetch_pkg::beat_data_t       out_data,
    input  wire logic                        out_valid,
    input  wire logic                        out_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    // A stalled request keeps its payload until accepted
    ar_hold: assert property (@(posedge clk) disable iff (!resetn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_len))
        else $error("AR request changed while stalled");

    // Accepted command puts the metadata request up at the next edge
    cmd_to_ar: assert property (@(posedge clk) disable iff (!resetn)
        cmd_valid && cmd_ready |=> ar_valid)
        else $error("No AR request after an accepted command");

    // Read data is a straight wire through
    pass_thru: assert property (@(posedge clk)
        out_data == r_data && out_valid == r_valid && r_ready == out_ready)
        else $error("Read data path is not a pass-through");

endmodule

`default_nettype wire

/* sim/data_fetch_tb.sv */
`default_nettype none

`include "data_fetch_consts.svh"

module data_fetch_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_CMDS   = 8;
    // Commands x 10 requests x 20 cycles each
    localparam int WATCHDOG_NS = NUM_CMDS * 10 * 20 * CLK_PERIOD;
    // Frame of 8192 bytes gives half-frame steps of 4096
    localparam logic [63:0] SP_STEP  = 64'd4096;
    localparam logic [63:0] FD_BYTES = 64'd12288;
    localparam logic [63:0] MD_BYTES = 64'd384;

    logic        clk;
    logic        resetn;
    logic [31:0] frame_size;
    logic [7:0]  cmd_data;
    logic        cmd_valid, cmd_ready;
    logic [63:0] ar_addr;
    logic [7:0]  ar_len;
    logic [2:0]  ar_size;
    logic [1:0]  ar_burst;
    logic        ar_valid, ar_ready;
    data_fetch_pkg::beat_data_t r_data, out_data;
    logic        r_valid, r_ready, out_valid, out_ready;
    logic        reg_wr_en, reg_wr_err, reg_rd_en, reg_rd_valid, reg_rd_err;
    logic [7:0]  reg_wr_index, reg_rd_index;
    logic [31:0] reg_wr_data, reg_rd_data;

    integer      seed;
    // Reference model of the ring layout and offsets
    logic [63:0] md_base_m [2];
    logic [63:0] fd_base_m [2][2];
    logic [63:0] md_off [2];
    logic [63:0] fd_off [2][2];
    logic [31:0] reg_word [17];
    // Phase 0 and 1 each get four commands so both wrap
    logic        cmd_phase [NUM_CMDS] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};

    data_fetch UUT (.*);

    bind data_fetch data_fetch_assert u_assert (
        .clk(clk), .resetn(resetn), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .ar_addr(ar_addr), .ar_len(ar_len), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r_data(r_data), .r_valid(r_valid), .r_ready(r_ready),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout, the run did not finish in time");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    // Random AR stalls and read-data traffic 10 ns after each edge
    initial begin
        forever begin
            @(posedge clk);
            #10;
            ar_ready  = ($random(seed) & 3) != 0;
            r_valid   = 1'($random(seed));
            out_ready = 1'($random(seed));
            for (int k = 0; k < 16; k++) r_data[k*32 +: 32] = $random(seed);
        end
    end

    task automatic check_eq(input string tname, input logic [63:0] expected,
                            input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("error %s expected %0h actual %0h", tname, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic write_reg(input int idx, input logic [31:0] data, input logic exp_err);
        @(posedge clk);
        #10;
        reg_wr_en    = 1'b1;
        reg_wr_index = idx[7:0];
        reg_wr_data  = data;
        @(posedge clk);
        #10;
        reg_wr_en = 1'b0;
        check_eq($sformatf("reg write err %0d", idx), 64'(exp_err), 64'(reg_wr_err));
    endtask

    task automatic read_reg(input int idx, input logic [31:0] exp_data, input logic exp_err);
        @(posedge clk);
        #10;
        reg_rd_en    = 1'b1;
        reg_rd_index = idx[7:0];
        @(posedge clk);
        #10;
        reg_rd_en = 1'b0;
        check_eq($sformatf("reg read valid %0d", idx), 64'd1, 64'(reg_rd_valid));
        check_eq($sformatf("reg read err %0d", idx), 64'(exp_err), 64'(reg_rd_err));
        if (!exp_err) check_eq($sformatf("reg read data %0d", idx), 64'(exp_data),
                               64'(reg_rd_data));
    endtask

    // ========================================================================
    // One command, its five AR requests and the model update
    // ========================================================================
    task automatic run_command(input logic p, input int n);
        logic [63:0] exp_addr [5];
        logic [7:0]  exp_len [5];
        int          got;
        exp_addr[0] = md_base_m[p] + md_off[p];
        exp_addr[1] = fd_base_m[p][0] + fd_off[p][0];
        exp_addr[2] = exp_addr[1] + `DF_BURST_BYTES;
        exp_addr[3] = fd_base_m[p][1] + fd_off[p][1];
        exp_addr[4] = exp_addr[3] + `DF_BURST_BYTES;
        // Metadata is 2 beats and frame bursts are 32 beats of 64 bytes
        exp_len = '{8'd1, 8'd31, 8'd31, 8'd31, 8'd31};
        got = 0;
        @(posedge clk);
        #10;
        cmd_data  = {7'b0, p};
        cmd_valid = 1'b1;
        @(negedge clk);
        check_eq($sformatf("cmd %0d ready", n), 64'd1, 64'(cmd_ready));
        @(posedge clk);
        #10;
        cmd_valid = 1'b0;
        while (got < 5) begin
            @(negedge clk);
            check_eq($sformatf("cmd %0d ar_valid", n), 64'd1, 64'(ar_valid));
            check_eq($sformatf("cmd %0d busy", n), 64'd0, 64'(cmd_ready));
            if (ar_ready) begin
                check_eq($sformatf("cmd %0d req %0d addr", n, got), exp_addr[got], ar_addr);
                check_eq($sformatf("cmd %0d req %0d len", n, got), 64'(exp_len[got]),
                         64'(ar_len));
                check_eq($sformatf("cmd %0d ar_size", n), 64'd6, 64'(ar_size));
                check_eq($sformatf("cmd %0d ar_burst", n), 64'd1, 64'(ar_burst));
                got++;
            end
        end
        @(negedge clk);
        check_eq($sformatf("cmd %0d ready after", n), 64'd1, 64'(cmd_ready));
        check_eq($sformatf("cmd %0d idle ar_valid", n), 64'd0, 64'(ar_valid));
        // Advance and wrap to zero at the buffer end
        md_off[p]    = (md_off[p] + `DF_MD_BYTES < MD_BYTES) ? md_off[p] + `DF_MD_BYTES : 0;
        fd_off[p][0] = (fd_off[p][0] + SP_STEP < FD_BYTES) ? fd_off[p][0] + SP_STEP : 0;
        fd_off[p][1] = (fd_off[p][1] + SP_STEP < FD_BYTES) ? fd_off[p][1] + SP_STEP : 0;
    endtask

    initial begin
        seed = 32'h4037;
        resetn = 1'b0;
        frame_size = 32'd8192;
        cmd_data = '0;
        cmd_valid = 1'b0;
        ar_ready = 1'b0;
        r_data = '0;
        r_valid = 1'b0;
        out_ready = 1'b0;
        reg_wr_en = 1'b0;
        reg_wr_index = '0;
        reg_wr_data = '0;
        reg_rd_en = 1'b0;
        reg_rd_index = '0;
        md_base_m = '{64'h0000_0001_2000_0000, 64'h0000_0002_4000_0000};
        fd_base_m = '{'{64'h0000_0010_0000_0000, 64'h0000_0011_8000_0000},
                      '{64'h0000_0020_0010_0000, 64'h0000_0021_0020_0000}};
        md_off = '{64'd0, 64'd0};
        fd_off = '{'{64'd0, 64'd0}, '{64'd0, 64'd0}};
        // Register words in map order with the high half first
        for (int i = 0; i < 4; i++) begin
            reg_word[1 + 2*i] = fd_base_m[i / 2][i % 2][63:32];
            reg_word[2 + 2*i] = fd_base_m[i / 2][i % 2][31:0];
        end
        for (int i = 0; i < 2; i++) begin
            reg_word[9 + 2*i]  = md_base_m[i][63:32];
            reg_word[10 + 2*i] = md_base_m[i][31:0];
        end
        reg_word[13] = FD_BYTES[63:32];
        reg_word[14] = FD_BYTES[31:0];
        reg_word[15] = MD_BYTES[63:32];
        reg_word[16] = MD_BYTES[31:0];
        repeat (3) @(posedge clk);
        #10;
        resetn = 1'b1;
        @(negedge clk);
        check_eq("reset cmd_ready", 64'd1, 64'(cmd_ready));
        check_eq("reset ar_valid", 64'd0, 64'(ar_valid));
        check_eq("reset reg_rd_valid", 64'd0, 64'(reg_rd_valid));

        // Register file
        for (int i = 1; i <= 16; i++) write_reg(i, reg_word[i], 1'b0);
        write_reg(`DF_REG_MODULE_REV, 32'hdead_beef, 1'b1);
        write_reg(20, 32'h1234_5678, 1'b1);
        for (int i = 1; i <= 16; i++) read_reg(i, reg_word[i], 1'b0);
        read_reg(`DF_REG_MODULE_REV, 32'd1, 1'b0);
        read_reg(20, 32'd0, 1'b1);

        // Command sequence with ring wrap on both phases
        for (int n = 0; n < NUM_CMDS; n++) run_command(cmd_phase[n], n);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
